//--- hw/mem_pkg.sv
package mem_pkg;

  // meaningful widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  // response codes, AXI style
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // array geometry
  localparam int MEM_WORDS  = 1024;
  localparam int WORD_IDX_W = 10;

  // port-1 fetch burst
  localparam int BURST_BEATS = 4;

  // read address request, burst flag set by the arbiter for port 1
  typedef struct packed {
    addr_t addr;
    logic  burst;
  } ar_req_t;

  // one read data beat
  typedef struct packed {
    data_t data;
    resp_t resp;
    logic  last;
  } r_beat_t;

  // write address, data and strobes travel together
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } w_req_t;

  // read channel owner
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_PORT1,
    RD_PORT2
  } rd_grant_e;

  // write channel owner
  typedef enum logic {
    WR_IDLE,
    WR_PORT2
  } wr_grant_e;

  // read engine FSM
  typedef enum logic [1:0] {
    RE_IDLE,
    RE_FETCH,
    RE_BEAT
  } rd_eng_e;

endpackage

//--- hw/sram_array.sv
module sram_array (
  input  logic                            clk,
  input  logic [mem_pkg::WORD_IDX_W-1:0]  rd_idx,
  output mem_pkg::data_t                  rd_data,
  input  logic                            wr_en,
  input  logic [mem_pkg::WORD_IDX_W-1:0]  wr_idx,
  input  mem_pkg::data_t                  wr_data,
  input  mem_pkg::strb_t                  wr_strb
);

  mem_pkg::data_t mem [mem_pkg::MEM_WORDS];

  // registered read, one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_idx];
  end

  // byte lanes gated by strobe
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < $bits(mem_pkg::strb_t); b++) begin
        if (wr_strb[b]) begin
          mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

endmodule

//--- hw/sram_read_engine.sv
module sram_read_engine (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            arvalid,
  input  mem_pkg::ar_req_t                ar,
  output logic                            arready,
  output logic                            rvalid,
  output mem_pkg::r_beat_t                r,
  input  logic                            rready,
  output logic [mem_pkg::WORD_IDX_W-1:0]  rd_idx,
  input  mem_pkg::data_t                  rd_data
);

  mem_pkg::rd_eng_e state;
  mem_pkg::addr_t   cur_addr;
  logic             cur_burst;
  logic [$clog2(mem_pkg::BURST_BEATS)-1:0] beat_cnt;

  logic in_range;
  logic last_beat;

  // word index must fall inside the array
  assign in_range  = (cur_addr >> 2) < mem_pkg::addr_t'(mem_pkg::MEM_WORDS);
  assign last_beat = !cur_burst ||
                     (beat_cnt == $bits(beat_cnt)'(mem_pkg::BURST_BEATS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= mem_pkg::RE_IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        mem_pkg::RE_IDLE: begin
          if (arvalid) begin
            state    <= mem_pkg::RE_FETCH;
            beat_cnt <= '0;
          end
        end
        // array samples rd_idx here
        mem_pkg::RE_FETCH: state <= mem_pkg::RE_BEAT;
        mem_pkg::RE_BEAT: begin
          if (rready) begin
            if (last_beat) begin
              state <= mem_pkg::RE_IDLE;
            end else begin
              state    <= mem_pkg::RE_FETCH;
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: state <= mem_pkg::RE_IDLE;
      endcase
    end
  end

  // address walks one word per beat
  always_ff @(posedge clk) begin
    if (state == mem_pkg::RE_IDLE && arvalid) begin
      cur_addr  <= ar.addr;
      cur_burst <= ar.burst;
    end else if (state == mem_pkg::RE_BEAT && rready && !last_beat) begin
      cur_addr <= cur_addr + mem_pkg::addr_t'(4);
    end
  end

  assign arready = (state == mem_pkg::RE_IDLE);
  assign rvalid  = (state == mem_pkg::RE_BEAT);
  assign rd_idx  = cur_addr[mem_pkg::WORD_IDX_W+1:2];

  // index is held while stalled, so the beat stays put
  assign r.data = in_range ? rd_data : '0;
  assign r.resp = in_range ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
  assign r.last = last_beat;

endmodule

//--- hw/sram_write_engine.sv
module sram_write_engine (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            awvalid,
  input  logic                            wvalid,
  input  mem_pkg::w_req_t                 w,
  output logic                            awready,
  output logic                            wready,
  output logic                            bvalid,
  output mem_pkg::resp_t                  bresp,
  input  logic                            bready,
  output logic                            wr_en,
  output logic [mem_pkg::WORD_IDX_W-1:0]  wr_idx,
  output mem_pkg::data_t                  wr_data,
  output mem_pkg::strb_t                  wr_strb
);

  logic           b_pend;
  mem_pkg::resp_t b_resp_q;

  logic accept;
  logic in_range;

  // one store in flight at a time
  assign accept   = awvalid && wvalid && !b_pend;
  assign in_range = (w.addr >> 2) < mem_pkg::addr_t'(mem_pkg::MEM_WORDS);

  assign awready = accept;
  assign wready  = accept;

  // array write on the accept edge
  assign wr_en   = accept && in_range;
  assign wr_idx  = w.addr[mem_pkg::WORD_IDX_W+1:2];
  assign wr_data = w.data;
  assign wr_strb = w.strb;

  always_ff @(posedge clk) begin
    if (rst) begin
      b_pend <= 1'b0;
    end else if (accept) begin
      b_pend <= 1'b1;
    end else if (b_pend && bready) begin
      b_pend <= 1'b0;
    end
  end

  // out of range stores only report SLVERR
  always_ff @(posedge clk) begin
    if (accept) begin
      b_resp_q <= in_range ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
    end
  end

  assign bvalid = b_pend;
  assign bresp  = b_resp_q;

endmodule

//--- hw/mem_arbiter.sv
module mem_arbiter (
  input  logic              clk,
  input  logic              rst,
  // port 1, fetch reads
  input  logic              arvalid1,
  input  mem_pkg::addr_t    araddr1,
  output logic              arready1,
  output logic              rvalid1,
  output mem_pkg::r_beat_t  r1,
  input  logic              rready1,
  // port 2, load reads
  input  logic              arvalid2,
  input  mem_pkg::addr_t    araddr2,
  output logic              arready2,
  output logic              rvalid2,
  output mem_pkg::r_beat_t  r2,
  input  logic              rready2,
  // port 2, stores
  input  logic              awvalid2,
  input  logic              wvalid2,
  input  mem_pkg::w_req_t   w2,
  output logic              awready2,
  output logic              wready2,
  output logic              bvalid2,
  output mem_pkg::resp_t    bresp2,
  input  logic              bready2,
  // slave side
  output logic              arvalid,
  output mem_pkg::ar_req_t  ar,
  input  logic              arready,
  input  logic              rvalid,
  input  mem_pkg::r_beat_t  r,
  output logic              rready,
  output logic              awvalid,
  output logic              wvalid,
  output mem_pkg::w_req_t   w,
  input  logic              awready,
  input  logic              wready,
  input  logic              bvalid,
  input  mem_pkg::resp_t    bresp,
  output logic              bready
);

  mem_pkg::rd_grant_e rd_state;
  mem_pkg::wr_grant_e wr_state;

  logic rd_g1;
  logic rd_g2;
  logic wr_g2;
  logic r_hs;

  assign rd_g1 = (rd_state == mem_pkg::RD_PORT1);
  assign rd_g2 = (rd_state == mem_pkg::RD_PORT2);
  assign wr_g2 = (wr_state == mem_pkg::WR_PORT2);
  assign r_hs  = rvalid && rready;

  // read grant, port 1 has fixed priority
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= mem_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        mem_pkg::RD_IDLE: begin
          if (arvalid1) begin
            rd_state <= mem_pkg::RD_PORT1;
          end else if (arvalid2) begin
            rd_state <= mem_pkg::RD_PORT2;
          end
        end
        mem_pkg::RD_PORT1: begin
          // whole burst must drain
          if (r_hs && r.last) begin
            rd_state <= mem_pkg::RD_IDLE;
          end
        end
        mem_pkg::RD_PORT2: begin
          if (r_hs) begin
            rd_state <= mem_pkg::RD_IDLE;
          end
        end
        default: rd_state <= mem_pkg::RD_IDLE;
      endcase
    end
  end

  // write grant, only port 2 stores
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= mem_pkg::WR_IDLE;
    end else begin
      case (wr_state)
        mem_pkg::WR_IDLE: begin
          if (awvalid2 && wvalid2) begin
            wr_state <= mem_pkg::WR_PORT2;
          end
        end
        mem_pkg::WR_PORT2: begin
          if (bvalid && bready) begin
            wr_state <= mem_pkg::WR_IDLE;
          end
        end
        default: wr_state <= mem_pkg::WR_IDLE;
      endcase
    end
  end

  // steer granted read request onto the slave
  always_comb begin
    arvalid = 1'b0;
    ar      = '0;
    rready  = 1'b0;
    if (rd_g1) begin
      arvalid  = arvalid1;
      ar.addr  = araddr1;
      ar.burst = 1'b1;
      rready   = rready1;
    end else if (rd_g2) begin
      arvalid  = arvalid2;
      ar.addr  = araddr2;
      ar.burst = 1'b0;
      rready   = rready2;
    end
  end

  assign awvalid = wr_g2 && awvalid2;
  assign wvalid  = wr_g2 && wvalid2;
  assign w       = wr_g2 ? w2 : '0;
  assign bready  = wr_g2 && bready2;

  // responses reach the owner only
  assign arready1 = rd_g1 && arready;
  assign rvalid1  = rd_g1 && rvalid;
  assign r1       = rd_g1 ? r : '0;

  assign arready2 = rd_g2 && arready;
  assign rvalid2  = rd_g2 && rvalid;
  assign r2       = rd_g2 ? r : '0;

  assign awready2 = wr_g2 && awready;
  assign wready2  = wr_g2 && wready;
  assign bvalid2  = wr_g2 && bvalid;
  assign bresp2   = wr_g2 ? bresp : mem_pkg::RESP_OKAY;

endmodule

//--- hw/mem_subsys_top.sv
module mem_subsys_top (
  input  logic              clk,
  input  logic              rst,
  // port 1 read
  input  logic              arvalid1,
  input  mem_pkg::addr_t    araddr1,
  output logic              arready1,
  output logic              rvalid1,
  output mem_pkg::r_beat_t  r1,
  input  logic              rready1,
  // port 2 read
  input  logic              arvalid2,
  input  mem_pkg::addr_t    araddr2,
  output logic              arready2,
  output logic              rvalid2,
  output mem_pkg::r_beat_t  r2,
  input  logic              rready2,
  // port 2 write
  input  logic              awvalid2,
  input  logic              wvalid2,
  input  mem_pkg::w_req_t   w2,
  output logic              awready2,
  output logic              wready2,
  output logic              bvalid2,
  output mem_pkg::resp_t    bresp2,
  input  logic              bready2
);

  // slave-side channels
  logic             s_arvalid;
  mem_pkg::ar_req_t s_ar;
  logic             s_arready;
  logic             s_rvalid;
  mem_pkg::r_beat_t s_r;
  logic             s_rready;
  logic             s_awvalid;
  logic             s_wvalid;
  mem_pkg::w_req_t  s_w;
  logic             s_awready;
  logic             s_wready;
  logic             s_bvalid;
  mem_pkg::resp_t   s_bresp;
  logic             s_bready;

  // array ports
  logic [mem_pkg::WORD_IDX_W-1:0] rd_idx;
  mem_pkg::data_t                 rd_data;
  logic                           wr_en;
  logic [mem_pkg::WORD_IDX_W-1:0] wr_idx;
  mem_pkg::data_t                 wr_data;
  mem_pkg::strb_t                 wr_strb;

  mem_arbiter u_arbiter (
    .clk      (clk),       .rst      (rst),
    .arvalid1 (arvalid1),  .araddr1  (araddr1),  .arready1 (arready1),
    .rvalid1  (rvalid1),   .r1       (r1),       .rready1  (rready1),
    .arvalid2 (arvalid2),  .araddr2  (araddr2),  .arready2 (arready2),
    .rvalid2  (rvalid2),   .r2       (r2),       .rready2  (rready2),
    .awvalid2 (awvalid2),  .wvalid2  (wvalid2),  .w2       (w2),
    .awready2 (awready2),  .wready2  (wready2),  .bvalid2  (bvalid2),
    .bresp2   (bresp2),    .bready2  (bready2),
    .arvalid  (s_arvalid), .ar       (s_ar),     .arready  (s_arready),
    .rvalid   (s_rvalid),  .r        (s_r),      .rready   (s_rready),
    .awvalid  (s_awvalid), .wvalid   (s_wvalid), .w        (s_w),
    .awready  (s_awready), .wready   (s_wready), .bvalid   (s_bvalid),
    .bresp    (s_bresp),   .bready   (s_bready)
  );

  sram_read_engine u_rd_eng (
    .clk     (clk),       .rst     (rst),
    .arvalid (s_arvalid), .ar      (s_ar),     .arready (s_arready),
    .rvalid  (s_rvalid),  .r       (s_r),      .rready  (s_rready),
    .rd_idx  (rd_idx),    .rd_data (rd_data)
  );

  sram_write_engine u_wr_eng (
    .clk     (clk),       .rst     (rst),
    .awvalid (s_awvalid), .wvalid  (s_wvalid), .w       (s_w),
    .awready (s_awready), .wready  (s_wready), .bvalid  (s_bvalid),
    .bresp   (s_bresp),   .bready  (s_bready),
    .wr_en   (wr_en),     .wr_idx  (wr_idx),   .wr_data (wr_data),
    .wr_strb (wr_strb)
  );

  sram_array u_array (
    .clk     (clk),
    .rd_idx  (rd_idx),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_data (wr_data),
    .wr_strb (wr_strb)
  );

endmodule

//--- sim/tb_mem_subsys.sv
module tb_mem_subsys;

  localparam int TIMEOUT = 200;
  // handshake selectors
  localparam int HS_AR1 = 0;
  localparam int HS_AR2 = 1;
  localparam int HS_R2  = 2;
  localparam int HS_AW  = 3;
  localparam int HS_B   = 4;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_BURST1,
    OP_READ2,
    OP_DUAL
  } op_kind_e;

  typedef struct packed {
    op_kind_e       kind;
    mem_pkg::addr_t addr;
    mem_pkg::data_t data;
    mem_pkg::strb_t strb;
    logic           stall;
  } op_t;

  logic             clk;
  logic             rst;
  logic             arvalid1;
  mem_pkg::addr_t   araddr1;
  logic             arready1;
  logic             rvalid1;
  mem_pkg::r_beat_t r1;
  logic             rready1;
  logic             arvalid2;
  mem_pkg::addr_t   araddr2;
  logic             arready2;
  logic             rvalid2;
  mem_pkg::r_beat_t r2;
  logic             rready2;
  logic             awvalid2;
  logic             wvalid2;
  mem_pkg::w_req_t  w2;
  logic             awready2;
  logic             wready2;
  logic             bvalid2;
  mem_pkg::resp_t   bresp2;
  logic             bready2;

  op_t            ops [$];
  mem_pkg::data_t shadow [mem_pkg::MEM_WORDS];
  // set while port 2 must stay locked out
  logic           lock_p2;

  mem_subsys_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_data(input string name, input mem_pkg::data_t got,
                            input mem_pkg::data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input mem_pkg::resp_t got,
                            input mem_pkg::resp_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_last(input string port, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s.last: got 0x%h, expected 0x%h", port, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // byte address below the array size in bytes
  function automatic logic in_range(input mem_pkg::addr_t a);
    return a < mem_pkg::addr_t'(4 * mem_pkg::MEM_WORDS);
  endfunction

  function automatic mem_pkg::data_t exp_word(input mem_pkg::addr_t a);
    return in_range(a) ? shadow[a[mem_pkg::WORD_IDX_W+1:2]] : '0;
  endfunction

  function automatic mem_pkg::resp_t exp_resp(input mem_pkg::addr_t a);
    return in_range(a) ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
  endfunction

  function automatic logic hs_now(input int kind);
    case (kind)
      HS_AR1:  return arvalid1 && arready1;
      HS_AR2:  return arvalid2 && arready2;
      HS_R2:   return rvalid2 && rready2;
      HS_AW:   return awvalid2 && awready2 && wready2;
      HS_B:    return bvalid2 && bready2;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic pick_rready(input logic stall);
    return stall ? 1'($urandom) : 1'b1;
  endfunction

  // sample on the falling edge where outputs have settled
  task automatic step();
    @(negedge clk);
    if (lock_p2 && (arready2 || rvalid2)) begin
      abort_run("port 2 was served while a port-1 burst was still in flight");
    end
  endtask

  task automatic wait_hs(input int kind, input string what);
    int cnt = 0;
    step();
    while (!hs_now(kind)) begin
      cnt++;
      if (cnt >= TIMEOUT) begin
        abort_run($sformatf("timeout waiting for %s", what));
      end
      step();
    end
  endtask

  task automatic add_op(input op_kind_e kind, input mem_pkg::addr_t addr,
                        input mem_pkg::data_t data, input mem_pkg::strb_t strb,
                        input logic stall);
    op_t op;
    op.kind  = kind;
    op.addr  = addr;
    op.data  = data;
    op.strb  = strb;
    op.stall = stall;
    ops.push_back(op);
  endtask

  task automatic do_write(input op_t op);
    mem_pkg::data_t mask;
    mask = {{8{op.strb[3]}}, {8{op.strb[2]}}, {8{op.strb[1]}}, {8{op.strb[0]}}};
    @(posedge clk);
    awvalid2 <= 1'b1;
    wvalid2  <= 1'b1;
    w2.addr  <= op.addr;
    w2.data  <= op.data;
    w2.strb  <= op.strb;
    wait_hs(HS_AW, "write address and data");
    @(posedge clk);
    awvalid2 <= 1'b0;
    wvalid2  <= 1'b0;
    bready2  <= 1'b1;
    // out of range leaves the shadow alone
    if (in_range(op.addr)) begin
      shadow[op.addr[mem_pkg::WORD_IDX_W+1:2]] =
        (shadow[op.addr[mem_pkg::WORD_IDX_W+1:2]] & ~mask) | (op.data & mask);
    end
    wait_hs(HS_B, "write response");
    check_resp("bresp2", bresp2, exp_resp(op.addr));
    @(posedge clk);
    bready2 <= 1'b0;
  endtask

  task automatic issue_reads(input logic do1, input mem_pkg::addr_t a1,
                             input logic do2, input mem_pkg::addr_t a2);
    @(posedge clk);
    arvalid1 <= do1;
    araddr1  <= a1;
    arvalid2 <= do2;
    araddr2  <= a2;
  endtask

  task automatic finish_read2(input mem_pkg::addr_t a);
    wait_hs(HS_AR2, "port-2 read address");
    @(posedge clk);
    arvalid2 <= 1'b0;
    rready2  <= 1'b1;
    wait_hs(HS_R2, "port-2 read data");
    check_data("r2.data", r2.data, exp_word(a));
    check_resp("r2.resp", r2.resp, exp_resp(a));
    check_last("r2", r2.last, 1'b1);
    @(posedge clk);
    rready2 <= 1'b0;
  endtask

  task automatic finish_burst(input mem_pkg::addr_t base, input logic stall);
    mem_pkg::addr_t a;
    logic           done;
    int             cnt;
    wait_hs(HS_AR1, "port-1 read address");
    @(posedge clk);
    arvalid1 <= 1'b0;
    rready1  <= pick_rready(stall);
    for (int b = 0; b < mem_pkg::BURST_BEATS; b++) begin
      a    = base + mem_pkg::addr_t'(4 * b);
      done = 1'b0;
      cnt  = 0;
      while (!done) begin
        step();
        // stalled beat already holds its final values
        if (rvalid1) begin
          check_data("r1.data", r1.data, exp_word(a));
          check_resp("r1.resp", r1.resp, exp_resp(a));
          check_last("r1", r1.last, b == mem_pkg::BURST_BEATS - 1);
        end
        done = rvalid1 && rready1;
        cnt++;
        if (!done && cnt >= TIMEOUT) begin
          abort_run($sformatf("timeout waiting for port-1 beat %0d", b));
        end
        @(posedge clk);
        rready1 <= (done && b == mem_pkg::BURST_BEATS - 1) ? 1'b0 : pick_rready(stall);
      end
    end
    // no fifth beat
    step();
    check_flag("rvalid1", rvalid1, 1'b0);
  endtask

  initial begin
    mem_pkg::addr_t a2;
    void'($urandom(32'hb134_0663));
    rst      = 1'b1;
    arvalid1 = 1'b0;
    araddr1  = '0;
    rready1  = 1'b0;
    arvalid2 = 1'b0;
    araddr2  = '0;
    rready2  = 1'b0;
    awvalid2 = 1'b0;
    wvalid2  = 1'b0;
    w2       = '0;
    bready2  = 1'b0;
    lock_p2  = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    step();
    check_flag("arready1", arready1, 1'b0);
    check_flag("rvalid1", rvalid1, 1'b0);
    check_flag("arready2", arready2, 1'b0);
    check_flag("rvalid2", rvalid2, 1'b0);
    check_flag("awready2", awready2, 1'b0);
    check_flag("wready2", wready2, 1'b0);
    check_flag("bvalid2", bvalid2, 1'b0);

    // kind, address, data, strobe, random rready on port 1
    add_op(OP_WRITE,  32'h0000_0000, 32'h1111_0000, 4'hf, 1'b0);
    add_op(OP_WRITE,  32'h0000_0004, 32'h2222_0004, 4'hf, 1'b0);
    add_op(OP_WRITE,  32'h0000_0008, 32'h3333_0008, 4'hf, 1'b0);
    add_op(OP_WRITE,  32'h0000_000c, 32'h4444_000c, 4'hf, 1'b0);
    add_op(OP_WRITE,  32'h0000_0010, 32'hdead_beef, 4'hf, 1'b0);
    add_op(OP_WRITE,  32'h0000_0010, 32'h1122_3344, 4'h5, 1'b0);
    add_op(OP_WRITE,  32'h0000_0014, 32'hcafe_f00d, 4'hf, 1'b0);
    add_op(OP_WRITE,  32'h0000_0014, 32'ha500_0000, 4'h8, 1'b0);
    add_op(OP_WRITE,  32'h0000_0014, 32'h0000_7700, 4'h2, 1'b0);
    add_op(OP_READ2,  32'h0000_0010, 32'h0, 4'h0, 1'b0);
    add_op(OP_READ2,  32'h0000_0014, 32'h0, 4'h0, 1'b0);
    add_op(OP_BURST1, 32'h0000_0000, 32'h0, 4'h0, 1'b0);
    add_op(OP_DUAL,   32'h0000_0000, 32'h0, 4'h0, 1'b0);
    add_op(OP_WRITE,  32'h0000_0ff8, 32'h5555_0ff8, 4'hf, 1'b0);
    add_op(OP_WRITE,  32'h0000_0ffc, 32'h6666_0ffc, 4'hf, 1'b0);
    // index bits of these alias words 0 and 1
    add_op(OP_WRITE,  32'h0000_1000, 32'hffff_ffff, 4'hf, 1'b0);
    add_op(OP_WRITE,  32'h0000_1004, 32'heeee_eeee, 4'hf, 1'b0);
    add_op(OP_READ2,  32'h0000_0000, 32'h0, 4'h0, 1'b0);
    add_op(OP_READ2,  32'h0000_0004, 32'h0, 4'h0, 1'b0);
    add_op(OP_READ2,  32'h0000_2000, 32'h0, 4'h0, 1'b0);
    add_op(OP_BURST1, 32'h0000_0ff8, 32'h0, 4'h0, 1'b0);
    add_op(OP_BURST1, 32'h0000_0000, 32'h0, 4'h0, 1'b1);
    add_op(OP_BURST1, 32'h0000_0ff8, 32'h0, 4'h0, 1'b1);
    add_op(OP_DUAL,   32'h0000_0004, 32'h0, 4'h0, 1'b1);
    add_op(OP_BURST1, 32'h0000_0008, 32'h0, 4'h0, 1'b1);

    foreach (ops[i]) begin
      case (ops[i].kind)
        OP_WRITE: do_write(ops[i]);
        OP_READ2: begin
          issue_reads(1'b0, '0, 1'b1, ops[i].addr);
          finish_read2(ops[i].addr);
        end
        OP_BURST1: begin
          issue_reads(1'b1, ops[i].addr, 1'b0, '0);
          finish_burst(ops[i].addr, ops[i].stall);
        end
        default: begin
          // port 2 wants the word just past the burst
          a2 = ops[i].addr + mem_pkg::addr_t'(4 * mem_pkg::BURST_BEATS);
          lock_p2 = 1'b1;
          issue_reads(1'b1, ops[i].addr, 1'b1, a2);
          finish_burst(ops[i].addr, ops[i].stall);
          lock_p2 = 1'b0;
          finish_read2(a2);
        end
      endcase
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- list.f
hw/mem_pkg.sv
hw/sram_array.sv
hw/sram_read_engine.sv
hw/sram_write_engine.sv
hw/mem_arbiter.sv
hw/mem_subsys_top.sv
sim/tb_mem_subsys.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing
TOP      := tb_mem_subsys
FILELIST := list.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, decide from $(LOG)"
	@echo "make clean  remove $(BUILD) and $(LOG)"
	@echo "make help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
